// File: verilog/reduction_pkg.sv
/*
  Shared definitions of the reduction offload block:
  reduction operation codes, FPU operation, rounding and format codes,
  and default operand widths
*/
`default_nettype none

package reduction_pkg;

  ////////////////////
  // Widths
  ////////////////////

  localparam int unsigned NarrowWidth = 64;
  // Fixed by the FP64 format of the wide path
  localparam int unsigned WideWidth = 64;

  ////////////////////
  // Reduction ops
  ////////////////////

  // Codes 8 to 15 are unused and treated as illegal
  typedef enum logic [3:0] {
    F_Add = 4'd0,
    F_Mul = 4'd1,
    F_Max = 4'd2,
    F_Min = 4'd3,
    A_Add = 4'd4,
    A_Mul = 4'd5,
    A_Max = 4'd6,
    A_Min = 4'd7
  } reduction_op_e;

  ////////////////////
  // FPU codes
  ////////////////////

  typedef enum logic [1:0] {
    ADD    = 2'd0,
    MUL    = 2'd1,
    MINMAX = 2'd2
  } fpu_op_e;

  // For MINMAX, RNE picks the maximum and RTZ the minimum
  typedef enum logic [2:0] {
    RNE = 3'd0,
    RTZ = 3'd1
  } fpu_rnd_e;

  typedef enum logic [2:0] {
    FP32    = 3'd0,
    FP64    = 3'd1,
    FP16    = 3'd2,
    FP8     = 3'd3,
    FP16ALT = 3'd4
  } fpu_fmt_e;

  typedef enum logic [1:0] {
    INT8  = 2'd0,
    INT16 = 2'd1,
    INT32 = 2'd2,
    INT64 = 2'd3
  } fpu_int_fmt_e;

endpackage

`default_nettype wire

// File: verilog/offload_if.sv
/*
  Offload port bundle: request with op and two operands,
  response with result, ctrl and data modports
*/
`default_nettype none

interface offload_if #(
  parameter int unsigned DataWidth = reduction_pkg::NarrowWidth
);
  import reduction_pkg::*;

  // Request side
  logic                 req_valid;
  logic                 req_ready;
  reduction_op_e        req_op;
  logic [DataWidth-1:0] req_operand1;
  logic [DataWidth-1:0] req_operand2;

  // Response side
  logic                 resp_valid;
  logic                 resp_ready;
  logic [DataWidth-1:0] resp_result;

  // Handshake sequencing
  modport ctrl (
    input  req_valid, resp_ready, req_op,
    output req_ready, resp_valid
  );

  // Operands in, result out
  modport data (
    input  req_op, req_operand1, req_operand2,
    output resp_result
  );

endinterface

`default_nettype wire

// File: verilog/narrow_alu_ctrl.sv
/*
  Narrow ALU control FSM: request acceptance,
  multiply step sequencing, result capture and response hold
*/
`default_nettype none

module narrow_alu_ctrl (
  input  logic      clk_i,
  input  logic      reset_i,
  offload_if.ctrl   off_if,
  input  logic      count_done_i,
  output logic      load_o,
  output logic      step_o,
  output logic      capture_o
);
  import reduction_pkg::*;

  typedef enum logic [1:0] {
    state_idle,
    state_multiply,
    state_respond
  } state_e;

  state_e state_q, state_d;
  // Set when the accepted request is a multiply
  logic   mul_q;

  assign off_if.req_ready  = (state_q == state_idle);
  assign off_if.resp_valid = (state_q == state_respond);

  assign load_o    = (state_q == state_idle) && off_if.req_valid;
  // Non-multiply ops capture on the first cycle in multiply
  assign step_o    = (state_q == state_multiply) && mul_q && !count_done_i;
  assign capture_o = (state_q == state_multiply) && (!mul_q || count_done_i);

  always_comb begin
    state_d = state_q;
    case (state_q)
      state_idle: begin
        if (off_if.req_valid) begin
          state_d = state_multiply;
        end
      end
      state_multiply: begin
        if (capture_o) begin
          state_d = state_respond;
        end
      end
      state_respond: begin
        // Hold result until taken
        if (off_if.resp_ready) begin
          state_d = state_idle;
        end
      end
      default: state_d = state_idle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= state_idle;
      mul_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      if (load_o) begin
        mul_q <= (off_if.req_op == A_Mul);
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/mul_step_counter.sv
/*
  Down-counter timing the shift-add multiply steps
*/
`default_nettype none

module mul_step_counter #(
  parameter int unsigned NarrowWidth = reduction_pkg::NarrowWidth
) (
  input  logic clk_i,
  input  logic reset_i,
  input  logic load_i,
  input  logic step_i,
  output logic done_o
);

  localparam int unsigned CountWidth = $clog2(NarrowWidth + 1);

  logic [CountWidth-1:0] count_q;

  // One step per multiplier bit
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count_q <= '0;
    end else if (load_i) begin
      count_q <= CountWidth'(NarrowWidth);
    end else if (step_i) begin
      count_q <= count_q - 1'b1;
    end
  end

  assign done_o = (count_q == '0);

endmodule

`default_nettype wire

// File: verilog/narrow_alu_datapath.sv
/*
  Narrow ALU datapath: operand and op registers, shared adder,
  signed compare, shift-add multiplier and result register
*/
`default_nettype none

module narrow_alu_datapath #(
  parameter int unsigned NarrowWidth = reduction_pkg::NarrowWidth
) (
  input  logic    clk_i,
  input  logic    reset_i,
  offload_if.data off_if,
  input  logic    load_i,
  input  logic    step_i,
  input  logic    capture_i
);
  import reduction_pkg::*;

  reduction_op_e          op_q;
  // Multiplicand shifts left, multiplier right
  logic [NarrowWidth-1:0] a_q;
  logic [NarrowWidth-1:0] b_q;
  logic [NarrowWidth-1:0] acc_q;
  logic [NarrowWidth-1:0] result_q;
  logic [NarrowWidth-1:0] result_d;
  logic [NarrowWidth-1:0] add_b;
  logic [NarrowWidth-1:0] sum;
  logic                   a_greater;

  ////////////////////
  // Arithmetic
  ////////////////////

  // One adder serves both the add op and the multiply steps
  assign add_b     = step_i ? acc_q : b_q;
  assign sum       = a_q + add_b;
  assign a_greater = $signed(a_q) > $signed(b_q);

  ////////////////////
  // Registers
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      op_q <= F_Add;
    end else if (load_i) begin
      op_q <= off_if.req_op;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_i) begin
      a_q   <= off_if.req_operand1;
      b_q   <= off_if.req_operand2;
      acc_q <= '0;
    end else if (step_i) begin
      // Add shifted multiplicand when multiplier LSB is set
      if (b_q[0]) begin
        acc_q <= sum;
      end
      a_q <= a_q << 1;
      b_q <= b_q >> 1;
    end
  end

  ////////////////////
  // Result
  ////////////////////

  always_comb begin
    case (op_q)
      A_Add:   result_d = sum;
      A_Mul:   result_d = acc_q;
      A_Max:   result_d = a_greater ? a_q : b_q;
      A_Min:   result_d = a_greater ? b_q : a_q;
      // F_ codes and unused codes
      default: result_d = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      result_q <= '0;
    end else if (capture_i) begin
      result_q <= result_d;
    end
  end

  assign off_if.resp_result = result_q;

endmodule

`default_nettype wire

// File: verilog/wide_fpu_req_encoder.sv
/*
  Wide reduction to FPU request translation:
  op code, rounding, formats and operand slots,
  handshake and response pass-through
*/
`default_nettype none

module wide_fpu_req_encoder (
  // Wide request
  input  logic                                wide_req_valid_i,
  input  reduction_pkg::reduction_op_e        wide_req_op_i,
  input  logic [reduction_pkg::WideWidth-1:0] wide_req_operand1_i,
  input  logic [reduction_pkg::WideWidth-1:0] wide_req_operand2_i,
  output logic                                wide_req_ready_o,
  // Wide response
  output logic                                wide_resp_valid_o,
  output logic [reduction_pkg::WideWidth-1:0] wide_resp_result_o,
  input  logic                                wide_resp_ready_i,
  // FPU request
  output logic                                fpu_req_valid_o,
  output reduction_pkg::fpu_op_e              fpu_op_o,
  output reduction_pkg::fpu_rnd_e             fpu_rnd_o,
  output reduction_pkg::fpu_fmt_e             fpu_src_fmt_o,
  output reduction_pkg::fpu_fmt_e             fpu_dst_fmt_o,
  output reduction_pkg::fpu_int_fmt_e         fpu_int_fmt_o,
  output logic [reduction_pkg::WideWidth-1:0] fpu_operand0_o,
  output logic [reduction_pkg::WideWidth-1:0] fpu_operand1_o,
  output logic [reduction_pkg::WideWidth-1:0] fpu_operand2_o,
  input  logic                                fpu_req_ready_i,
  // FPU response
  input  logic                                fpu_resp_valid_i,
  input  logic [reduction_pkg::WideWidth-1:0] fpu_resp_result_i,
  output logic                                fpu_resp_ready_o
);
  import reduction_pkg::*;

  // Handshakes and result go straight through
  assign fpu_req_valid_o    = wide_req_valid_i;
  assign wide_req_ready_o   = fpu_req_ready_i;
  assign wide_resp_valid_o  = fpu_resp_valid_i;
  assign fpu_resp_ready_o   = wide_resp_ready_i;
  assign wide_resp_result_o = fpu_resp_result_i;

  // Always double precision
  assign fpu_src_fmt_o = FP64;
  assign fpu_dst_fmt_o = FP64;
  assign fpu_int_fmt_o = INT64;

  always_comb begin
    fpu_op_o       = ADD;
    fpu_rnd_o      = RNE;
    fpu_operand0_o = '0;
    fpu_operand1_o = '0;
    fpu_operand2_o = '0;
    case (wide_req_op_i)
      // FPU adds the second and third slots
      F_Add: begin
        fpu_operand1_o = wide_req_operand1_i;
        fpu_operand2_o = wide_req_operand2_i;
      end
      F_Mul: begin
        fpu_op_o       = MUL;
        fpu_operand0_o = wide_req_operand1_i;
        fpu_operand1_o = wide_req_operand2_i;
      end
      F_Max: begin
        fpu_op_o       = MINMAX;
        fpu_operand0_o = wide_req_operand1_i;
        fpu_operand1_o = wide_req_operand2_i;
      end
      F_Min: begin
        fpu_op_o       = MINMAX;
        fpu_rnd_o      = RTZ;
        fpu_operand0_o = wide_req_operand1_i;
        fpu_operand1_o = wide_req_operand2_i;
      end
      default: begin
        fpu_op_o = ADD;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/reduction_offload_tile.sv
/*
  Reduction offload tile top level: narrow integer ALU
  (control, step counter, datapath) and wide FPU request encoder
*/
`default_nettype none

module reduction_offload_tile #(
  parameter int unsigned NarrowWidth = reduction_pkg::NarrowWidth
) (
  input  logic                                clk_i,
  input  logic                                reset_i,
  // Narrow request
  input  logic                                narrow_req_valid_i,
  input  reduction_pkg::reduction_op_e        narrow_req_op_i,
  input  logic [NarrowWidth-1:0]              narrow_req_operand1_i,
  input  logic [NarrowWidth-1:0]              narrow_req_operand2_i,
  output logic                                narrow_req_ready_o,
  // Narrow response
  output logic                                narrow_resp_valid_o,
  output logic [NarrowWidth-1:0]              narrow_resp_result_o,
  input  logic                                narrow_resp_ready_i,
  // Wide request
  input  logic                                wide_req_valid_i,
  input  reduction_pkg::reduction_op_e        wide_req_op_i,
  input  logic [reduction_pkg::WideWidth-1:0] wide_req_operand1_i,
  input  logic [reduction_pkg::WideWidth-1:0] wide_req_operand2_i,
  output logic                                wide_req_ready_o,
  // Wide response
  output logic                                wide_resp_valid_o,
  output logic [reduction_pkg::WideWidth-1:0] wide_resp_result_o,
  input  logic                                wide_resp_ready_i,
  // FPU request
  output logic                                fpu_req_valid_o,
  output reduction_pkg::fpu_op_e              fpu_op_o,
  output reduction_pkg::fpu_rnd_e             fpu_rnd_o,
  output reduction_pkg::fpu_fmt_e             fpu_src_fmt_o,
  output reduction_pkg::fpu_fmt_e             fpu_dst_fmt_o,
  output reduction_pkg::fpu_int_fmt_e         fpu_int_fmt_o,
  output logic [reduction_pkg::WideWidth-1:0] fpu_operand0_o,
  output logic [reduction_pkg::WideWidth-1:0] fpu_operand1_o,
  output logic [reduction_pkg::WideWidth-1:0] fpu_operand2_o,
  input  logic                                fpu_req_ready_i,
  // FPU response
  input  logic                                fpu_resp_valid_i,
  input  logic [reduction_pkg::WideWidth-1:0] fpu_resp_result_i,
  output logic                                fpu_resp_ready_o
);

  ////////////////////
  // Narrow ALU
  ////////////////////

  logic load;
  logic step;
  logic capture;
  logic count_done;

  offload_if #(.DataWidth(NarrowWidth)) narrow_if ();

  assign narrow_if.req_valid    = narrow_req_valid_i;
  assign narrow_if.req_op       = narrow_req_op_i;
  assign narrow_if.req_operand1 = narrow_req_operand1_i;
  assign narrow_if.req_operand2 = narrow_req_operand2_i;
  assign narrow_if.resp_ready   = narrow_resp_ready_i;
  assign narrow_req_ready_o     = narrow_if.req_ready;
  assign narrow_resp_valid_o    = narrow_if.resp_valid;
  assign narrow_resp_result_o   = narrow_if.resp_result;

  narrow_alu_ctrl i_ctrl (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .off_if       (narrow_if.ctrl),
    .count_done_i (count_done),
    .load_o       (load),
    .step_o       (step),
    .capture_o    (capture)
  );

  mul_step_counter #(
    .NarrowWidth (NarrowWidth)
  ) i_counter (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .load_i  (load),
    .step_i  (step),
    .done_o  (count_done)
  );

  narrow_alu_datapath #(
    .NarrowWidth (NarrowWidth)
  ) i_datapath (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .off_if    (narrow_if.data),
    .load_i    (load),
    .step_i    (step),
    .capture_i (capture)
  );

  ////////////////////
  // Wide FPU path
  ////////////////////

  wide_fpu_req_encoder i_wide_encoder (
    .wide_req_valid_i    (wide_req_valid_i),
    .wide_req_op_i       (wide_req_op_i),
    .wide_req_operand1_i (wide_req_operand1_i),
    .wide_req_operand2_i (wide_req_operand2_i),
    .wide_req_ready_o    (wide_req_ready_o),
    .wide_resp_valid_o   (wide_resp_valid_o),
    .wide_resp_result_o  (wide_resp_result_o),
    .wide_resp_ready_i   (wide_resp_ready_i),
    .fpu_req_valid_o     (fpu_req_valid_o),
    .fpu_op_o            (fpu_op_o),
    .fpu_rnd_o           (fpu_rnd_o),
    .fpu_src_fmt_o       (fpu_src_fmt_o),
    .fpu_dst_fmt_o       (fpu_dst_fmt_o),
    .fpu_int_fmt_o       (fpu_int_fmt_o),
    .fpu_operand0_o      (fpu_operand0_o),
    .fpu_operand1_o      (fpu_operand1_o),
    .fpu_operand2_o      (fpu_operand2_o),
    .fpu_req_ready_i     (fpu_req_ready_i),
    .fpu_resp_valid_i    (fpu_resp_valid_i),
    .fpu_resp_result_i   (fpu_resp_result_i),
    .fpu_resp_ready_o    (fpu_resp_ready_o)
  );

endmodule

`default_nettype wire

// File: verification/tb_reduction_offload_tile.sv
/*
  Testbench for the reduction offload tile: reset values, narrow ALU
  results, multiply, illegal codes, back-pressure, wide FPU request
  encoding and pass-through, checked against a reference model
*/
`default_nettype none

module tb_reduction_offload_tile;
  import reduction_pkg::*;

  localparam int unsigned Timeout = 200;

  logic                   clk_i;
  logic                   reset_i;
  logic                   narrow_req_valid_i;
  reduction_op_e          narrow_req_op_i;
  logic [NarrowWidth-1:0] narrow_req_operand1_i;
  logic [NarrowWidth-1:0] narrow_req_operand2_i;
  logic                   narrow_req_ready_o;
  logic                   narrow_resp_valid_o;
  logic [NarrowWidth-1:0] narrow_resp_result_o;
  logic                   narrow_resp_ready_i;
  logic                   wide_req_valid_i;
  reduction_op_e          wide_req_op_i;
  logic [WideWidth-1:0]   wide_req_operand1_i;
  logic [WideWidth-1:0]   wide_req_operand2_i;
  logic                   wide_req_ready_o;
  logic                   wide_resp_valid_o;
  logic [WideWidth-1:0]   wide_resp_result_o;
  logic                   wide_resp_ready_i;
  logic                   fpu_req_valid_o;
  fpu_op_e                fpu_op_o;
  fpu_rnd_e               fpu_rnd_o;
  fpu_fmt_e               fpu_src_fmt_o;
  fpu_fmt_e               fpu_dst_fmt_o;
  fpu_int_fmt_e           fpu_int_fmt_o;
  logic [WideWidth-1:0]   fpu_operand0_o;
  logic [WideWidth-1:0]   fpu_operand1_o;
  logic [WideWidth-1:0]   fpu_operand2_o;
  logic                   fpu_req_ready_i;
  logic                   fpu_resp_valid_i;
  logic [WideWidth-1:0]   fpu_resp_result_i;
  logic                   fpu_resp_ready_o;

  logic [31:0]            lfsr_state;
  int unsigned            checks;
  int unsigned            errors;

  reduction_offload_tile #(.NarrowWidth(NarrowWidth)) dut_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  ////////////////////
  // Random source
  ////////////////////

  // Galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic lfsr_bit();
    logic out;
    out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out) begin
      lfsr_state = lfsr_state ^ 32'h8020_0003;
    end
    return out;
  endfunction

  function automatic logic [63:0] rand_bits(input int unsigned n);
    logic [63:0] value;
    value = '0;
    for (int unsigned i = 0; i < n; i++) begin
      value = {value[62:0], lfsr_bit()};
    end
    return value;
  endfunction

  // Response ready about one cycle in four
  function automatic logic pick_ready();
    return rand_bits(2) == 64'd3;
  endfunction

  ////////////////////
  // Reference model
  ////////////////////

  function automatic logic [63:0] model_narrow(input reduction_op_e op,
                                               input logic [63:0] a, input logic [63:0] b);
    case (op)
      A_Add:   return a + b;
      A_Mul:   return a * b;
      A_Max:   return ($signed(a) >= $signed(b)) ? a : b;
      A_Min:   return ($signed(a) <= $signed(b)) ? a : b;
      default: return '0;
    endcase
  endfunction

  task automatic model_wide(input reduction_op_e op, input logic [63:0] a,
                            input logic [63:0] b, output fpu_op_e exp_op,
                            output fpu_rnd_e exp_rnd, output logic [63:0] e0,
                            output logic [63:0] e1, output logic [63:0] e2);
    exp_op  = ADD;
    exp_rnd = RNE;
    e0 = '0;
    e1 = '0;
    e2 = '0;
    case (op)
      F_Add: begin
        e1 = a;
        e2 = b;
      end
      F_Mul: begin
        exp_op = MUL;
        e0 = a;
        e1 = b;
      end
      F_Max: begin
        exp_op = MINMAX;
        e0 = a;
        e1 = b;
      end
      F_Min: begin
        exp_op  = MINMAX;
        exp_rnd = RTZ;
        e0 = a;
        e1 = b;
      end
      default: begin
        exp_op = ADD;
      end
    endcase
  endtask

  ////////////////////
  // Helpers
  ////////////////////

  task automatic step_cycle();
    @(posedge clk_i);
    #2;
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("Fail %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic report_timeout(input string what);
    errors++;
    $display("Timeout: %s", what);
  endtask

  // A request that must not be taken while the ALU is busy
  task automatic drive_stray(input logic enable);
    narrow_req_valid_i = enable;
    if (enable) begin
      narrow_req_op_i       = reduction_op_e'(4'(rand_bits(4)));
      narrow_req_operand1_i = rand_bits(64);
      narrow_req_operand2_i = rand_bits(64);
    end
  endtask

  task automatic narrow_transaction(input string name, input reduction_op_e op,
                                    input logic [63:0] a, input logic [63:0] b,
                                    input logic back_pressure);
    logic [63:0] expected;
    logic        ready_next;
    int unsigned cycles;
    expected = model_narrow(op, a, b);
    cycles = 0;
    while (!narrow_req_ready_o && cycles < Timeout) begin
      step_cycle();
      cycles++;
    end
    if (!narrow_req_ready_o) begin
      report_timeout({name, " request never accepted"});
      return;
    end
    narrow_req_valid_i    = 1'b1;
    narrow_req_op_i       = op;
    narrow_req_operand1_i = a;
    narrow_req_operand2_i = b;
    step_cycle();
    cycles = 0;
    while (!narrow_resp_valid_o && cycles < Timeout) begin
      check_value({name, " ready while busy"}, 64'd0, 64'(narrow_req_ready_o));
      drive_stray(back_pressure);
      narrow_resp_ready_i = back_pressure ? pick_ready() : 1'b1;
      step_cycle();
      cycles++;
    end
    if (!narrow_resp_valid_o) begin
      narrow_req_valid_i = 1'b0;
      report_timeout({name, " response never arrived"});
      return;
    end
    check_value(name, expected, narrow_resp_result_o);
    check_value({name, " ready with response"}, 64'd0, 64'(narrow_req_ready_o));
    ready_next = back_pressure ? pick_ready() : 1'b1;
    cycles = 0;
    while (!ready_next && cycles < Timeout) begin
      narrow_resp_ready_i = 1'b0;
      drive_stray(1'b1);
      step_cycle();
      cycles++;
      check_value({name, " valid held"}, 64'd1, 64'(narrow_resp_valid_o));
      check_value({name, " result held"}, expected, narrow_resp_result_o);
      check_value({name, " ready under back-pressure"}, 64'd0, 64'(narrow_req_ready_o));
      ready_next = pick_ready();
    end
    if (!ready_next) begin
      report_timeout({name, " response ready never drawn"});
    end
    // Drop the stray request so it is not taken once idle
    narrow_resp_ready_i = 1'b1;
    narrow_req_valid_i  = 1'b0;
    step_cycle();
    check_value({name, " valid after take"}, 64'd0, 64'(narrow_resp_valid_o));
    check_value({name, " ready after take"}, 64'd1, 64'(narrow_req_ready_o));
  endtask

  task automatic wide_encoding_check(input logic [3:0] code);
    reduction_op_e op;
    logic [63:0]   a;
    logic [63:0]   b;
    logic [63:0]   e0;
    logic [63:0]   e1;
    logic [63:0]   e2;
    fpu_op_e       exp_op;
    fpu_rnd_e      exp_rnd;
    string         name;
    op = reduction_op_e'(code);
    a  = rand_bits(64);
    b  = rand_bits(64);
    model_wide(op, a, b, exp_op, exp_rnd, e0, e1, e2);
    step_cycle();
    wide_req_valid_i    = 1'b1;
    wide_req_op_i       = op;
    wide_req_operand1_i = a;
    wide_req_operand2_i = b;
    #1;
    name = $sformatf("wide code %0d", code);
    check_value({name, " op"}, 64'(exp_op), 64'(fpu_op_o));
    check_value({name, " rounding"}, 64'(exp_rnd), 64'(fpu_rnd_o));
    check_value({name, " src fmt"}, 64'(FP64), 64'(fpu_src_fmt_o));
    check_value({name, " dst fmt"}, 64'(FP64), 64'(fpu_dst_fmt_o));
    check_value({name, " int fmt"}, 64'(INT64), 64'(fpu_int_fmt_o));
    check_value({name, " operand0"}, e0, fpu_operand0_o);
    check_value({name, " operand1"}, e1, fpu_operand1_o);
    check_value({name, " operand2"}, e2, fpu_operand2_o);
  endtask

  task automatic wide_passthrough_check(input int unsigned index);
    string name;
    step_cycle();
    wide_req_valid_i  = 1'(rand_bits(1));
    fpu_req_ready_i   = 1'(rand_bits(1));
    fpu_resp_valid_i  = 1'(rand_bits(1));
    wide_resp_ready_i = 1'(rand_bits(1));
    fpu_resp_result_i = rand_bits(64);
    #1;
    name = $sformatf("wide pass %0d", index);
    check_value({name, " req valid"}, 64'(wide_req_valid_i), 64'(fpu_req_valid_o));
    check_value({name, " req ready"}, 64'(fpu_req_ready_i), 64'(wide_req_ready_o));
    check_value({name, " resp valid"}, 64'(fpu_resp_valid_i), 64'(wide_resp_valid_o));
    check_value({name, " resp ready"}, 64'(wide_resp_ready_i), 64'(fpu_resp_ready_o));
    check_value({name, " result"}, fpu_resp_result_i, wide_resp_result_o);
  endtask

  ////////////////////
  // Test sequence
  ////////////////////

  initial begin
    reduction_op_e op;
    logic [1:0]    sel;
    logic [63:0]   a;
    logic [63:0]   b;
    lfsr_state            = 32'h9eb5_37d4;
    checks                = 0;
    errors                = 0;
    reset_i               = 1'b1;
    narrow_req_valid_i    = 1'b0;
    narrow_req_op_i       = A_Add;
    narrow_req_operand1_i = '0;
    narrow_req_operand2_i = '0;
    narrow_resp_ready_i   = 1'b0;
    wide_req_valid_i      = 1'b0;
    wide_req_op_i         = F_Add;
    wide_req_operand1_i   = '0;
    wide_req_operand2_i   = '0;
    wide_resp_ready_i     = 1'b0;
    fpu_req_ready_i       = 1'b0;
    fpu_resp_valid_i      = 1'b0;
    fpu_resp_result_i     = '0;
    repeat (3) @(posedge clk_i);
    #2;
    reset_i = 1'b0;

    check_value("reset req ready", 64'd1, 64'(narrow_req_ready_o));
    check_value("reset resp valid", 64'd0, 64'(narrow_resp_valid_o));

    // Signed edge cases, then random add, max and min
    narrow_transaction("narrow max sign", A_Max, 64'h8000_0000_0000_0000, 64'd1, 1'b0);
    narrow_transaction("narrow min sign", A_Min, 64'h8000_0000_0000_0000, 64'd1, 1'b0);
    for (int i = 0; i < 30; i++) begin
      sel = 2'(rand_bits(2));
      case (sel)
        2'd0:    op = A_Add;
        2'd1:    op = A_Max;
        default: op = A_Min;
      endcase
      a = rand_bits(64);
      b = rand_bits(64);
      narrow_transaction($sformatf("narrow %s", op.name()), op, a, b, 1'b0);
    end

    for (int i = 0; i < 10; i++) begin
      a = rand_bits(64);
      b = rand_bits(64);
      narrow_transaction("narrow A_Mul", A_Mul, a, b, 1'b0);
    end
    for (int code = 0; code < 16; code++) begin
      if (code < 4 || code >= 8) begin
        a = rand_bits(64);
        b = rand_bits(64);
        op = reduction_op_e'(4'(code));
        narrow_transaction($sformatf("narrow code %0d", code), op, a, b, 1'b0);
      end
    end

    for (int i = 0; i < 24; i++) begin
      op = reduction_op_e'(4'(rand_bits(4)));
      a  = rand_bits(64);
      b  = rand_bits(64);
      narrow_transaction($sformatf("narrow stall code %0d", op), op, a, b, 1'b1);
    end

    for (int round = 0; round < 4; round++) begin
      for (int code = 0; code < 16; code++) begin
        wide_encoding_check(4'(code));
      end
    end
    for (int unsigned i = 0; i < 32; i++) begin
      wide_passthrough_check(i);
    end

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
verilog/reduction_pkg.sv
verilog/offload_if.sv
verilog/narrow_alu_ctrl.sv
verilog/mul_step_counter.sv
verilog/narrow_alu_datapath.sv
verilog/wide_fpu_req_encoder.sv
verilog/reduction_offload_tile.sv
verification/tb_reduction_offload_tile.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_reduction_offload_tile
FILELIST  = compile.f
BUILD_DIR = obj_dir
PASS_MSG  = No errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	@out="$$(./$(BUILD_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
